/* relay_alu.f */
+incdir+rtl
rtl/relay_alu_pkg.sv
rtl/alu_operand_regs.sv
rtl/alu_adder_unit.sv
rtl/alu_logic_unit.sv
rtl/alu_result_stage.sv
rtl/relay_alu.sv
test/tb_clock_gen.sv
test/tb_relay_alu.sv

/* rtl/alu_adder_unit.sv */
//////////////////////////////////////////////////
// ripple adder from per-bit dual-rail blocks
// purely combinational, settles in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "relay_alu_settings.svh"
`default_nettype none

module alu_adder_unit (
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic [`ALU_WIDTH-1:0] c,
  input  logic                  carry_in,
  output logic [`ALU_WIDTH-1:0] sum,
  output logic                  carry
);

  // carry rail pair between the blocks
  // index 0 is the chain input, top index the carry out
  logic [`ALU_WIDTH:0] carry_t;
  logic [`ALU_WIDTH:0] carry_n;

  // seed both rails from the single carry input
  assign carry_t[0] = carry_in;
  assign carry_n[0] = ~carry_in;

  //////////////////////////////////////////////////
  // per-bit adder blocks
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : g_bit
    logic diff;

    // inputs differ, so carry propagates
    assign diff = b[i] ^ c[i];

    // relay style sum, picks the rail by the input difference
    assign sum[i] = diff ? carry_n[i] : carry_t[i];

    // true rail: generate or propagate a 1
    assign carry_t[i+1] = (b[i] & c[i]) | (diff & carry_t[i]);
    // inverted rail: kill or propagate a 0
    assign carry_n[i+1] = (~b[i] & ~c[i]) | (diff & carry_n[i]);
  end

  assign carry = carry_t[`ALU_WIDTH];

  // rails are built separately, so check they stay complementary
  always_comb begin
    a_rails_complementary: assert (carry_t == ~carry_n);
  end

endmodule

`default_nettype wire

/* rtl/alu_logic_unit.sv */
//////////////////////////////////////////////////
// bitwise functions of the relay ALU
// zero out for add, inc and clr op-codes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "relay_alu_settings.svh"
`default_nettype none

module alu_logic_unit (
  input  relay_alu_pkg::alu_operands_t operands,
  input  relay_alu_pkg::alu_op_e       op,
  output logic [`ALU_WIDTH-1:0]        data
);

  import relay_alu_pkg::*;

  //////////////////////////////////////////////////
  // per-function results
  //////////////////////////////////////////////////

  logic [`ALU_WIDTH-1:0] and_data;
  logic [`ALU_WIDTH-1:0] or_data;
  logic [`ALU_WIDTH-1:0] xor_data;
  logic [`ALU_WIDTH-1:0] not_data;
  logic [`ALU_WIDTH-1:0] rol_data;

  assign and_data = operands.b & operands.c;
  assign or_data  = operands.b | operands.c;
  assign xor_data = operands.b ^ operands.c;

  // not and rotate use b only
  assign not_data = ~operands.b;
  // top bit wraps into bit 0
  assign rol_data = {operands.b[`ALU_WIDTH-2:0], operands.b[`ALU_WIDTH-1]};

  //////////////////////////////////////////////////
  // select by op-code
  //////////////////////////////////////////////////

  always_comb begin
    case (op)
      OP_AND:  data = and_data;
      OP_OR:   data = or_data;
      OP_XOR:  data = xor_data;
      OP_NOT:  data = not_data;
      OP_ROL:  data = rol_data;
      // arithmetic and clr give nothing here
      default: data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/alu_operand_regs.sv */
//////////////////////////////////////////////////
// B and C operand registers, one load strobe each
// new value visible one edge after the strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "relay_alu_settings.svh"
`default_nettype none

module alu_operand_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load_b,
  input  logic                         load_c,
  input  logic [`ALU_WIDTH-1:0]        b_data,
  input  logic [`ALU_WIDTH-1:0]        c_data,
  output relay_alu_pkg::alu_operands_t operands
);

  //////////////////////////////////////////////////
  // register storage
  //////////////////////////////////////////////////

  // b register
  // loads independently of c
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      operands.b <= '0;
    end else if (load_b) begin
      operands.b <= b_data;
    end
  end

  // c register
  // both may load on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      operands.c <= '0;
    end else if (load_c) begin
      operands.c <= c_data;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // loaded data must be known
  // an x here would ripple into every later result
  a_load_b_known: assert property (@(posedge clk) disable iff (!rst_n)
    load_b |-> !$isunknown(b_data));
  a_load_c_known: assert property (@(posedge clk) disable iff (!rst_n)
    load_c |-> !$isunknown(c_data));

endmodule

`default_nettype wire

/* rtl/alu_result_stage.sv */
//////////////////////////////////////////////////
// op decode, result select and flag register
// result_valid one cycle after op_strobe, no stall
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "relay_alu_settings.svh"
`default_nettype none

module alu_result_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         op_strobe,
  input  relay_alu_pkg::alu_op_e       op,
  input  relay_alu_pkg::alu_operands_t operands,
  output logic                         result_valid,
  output relay_alu_pkg::alu_result_t   result
);

  import relay_alu_pkg::*;

  logic                  is_arith;
  logic [`ALU_WIDTH-1:0] add_c;
  logic                  add_cin;
  logic [`ALU_WIDTH-1:0] add_sum;
  logic                  add_carry;
  logic [`ALU_WIDTH-1:0] logic_data;
  logic [`ALU_WIDTH-1:0] next_data;
  alu_flags_t            next_flags;

  //////////////////////////////////////////////////
  // adder operand steering
  //////////////////////////////////////////////////

  assign is_arith = (op == OP_ADD) || (op == OP_INC);

  // inc is b plus zero with carry in set
  assign add_c   = (op == OP_INC) ? '0 : operands.c;
  assign add_cin = (op == OP_INC);

  alu_adder_unit u_adder (
    .b        (operands.b),
    .c        (add_c),
    .carry_in (add_cin),
    .sum      (add_sum),
    .carry    (add_carry)
  );

  alu_logic_unit u_logic (
    .operands (operands),
    .op       (op),
    .data     (logic_data)
  );

  //////////////////////////////////////////////////
  // result select and flags
  //////////////////////////////////////////////////

  // clr falls through to the logic unit zero
  assign next_data        = is_arith ? add_sum : logic_data;
  assign next_flags.sign  = next_data[`ALU_WIDTH-1];
  // carry only from add and inc
  assign next_flags.carry = is_arith & add_carry;
  assign next_flags.zero  = (next_data == '0);

  // result held until the next op, valid is a one-cycle pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= op_strobe;
      if (op_strobe) begin
        result.data  <= next_data;
        result.flags <= next_flags;
      end
    end
  end

  // one result per strobe, exactly one cycle later
  a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
    op_strobe |=> result_valid);
  a_valid_has_op: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(op_strobe));
  a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
    op_strobe |-> !$isunknown(op));

endmodule

`default_nettype wire

/* rtl/relay_alu.sv */
//////////////////////////////////////////////////
// relay ALU top, operand registers and result stage
// ops see B and C as held before the strobe edge
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "relay_alu_settings.svh"
`default_nettype none

module relay_alu (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load_b,
  input  logic                       load_c,
  input  logic [`ALU_WIDTH-1:0]      b_data,
  input  logic [`ALU_WIDTH-1:0]      c_data,
  input  logic                       op_strobe,
  input  relay_alu_pkg::alu_op_e     op,
  output logic                       result_valid,
  output relay_alu_pkg::alu_result_t result
);

  import relay_alu_pkg::*;

  // registered b and c, read by every op
  alu_operands_t operands;

  //////////////////////////////////////////////////
  // operand registers
  //////////////////////////////////////////////////

  alu_operand_regs u_operand_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_b   (load_b),
    .load_c   (load_c),
    .b_data   (b_data),
    .c_data   (c_data),
    .operands (operands)
  );

  //////////////////////////////////////////////////
  // compute and result register
  //////////////////////////////////////////////////

  // a load in the strobe cycle lands after the op samples
  alu_result_stage u_result_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_strobe    (op_strobe),
    .op           (op),
    .operands     (operands),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* rtl/relay_alu_pkg.sv */
//////////////////////////////////////////////////
// shared types of the relay ALU subsystem
// widths come from relay_alu_settings.svh
//////////////////////////////////////////////////

`include "relay_alu_settings.svh"
`default_nettype none

package relay_alu_pkg;

  // function select, as wired on the relay op-code lines
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    // b plus c
    OP_ADD = 0,
    // b plus 1
    OP_INC = 1,
    OP_AND = 2,
    OP_OR  = 3,
    OP_XOR = 4,
    // inverse of b
    OP_NOT = 5,
    // b rotated left by one
    OP_ROL = 6,
    // zero result
    OP_CLR = 7
  } alu_op_e;

  // the two operand registers
  typedef struct packed {
    logic [`ALU_WIDTH-1:0] b;
    logic [`ALU_WIDTH-1:0] c;
  } alu_operands_t;

  // condition flags
  // carry only meaningful for add and inc
  typedef struct packed {
    logic sign;
    logic carry;
    logic zero;
  } alu_flags_t;

  // result word with its flags
  typedef struct packed {
    logic [`ALU_WIDTH-1:0] data;
    alu_flags_t            flags;
  } alu_result_t;

endpackage

`default_nettype wire

/* rtl/relay_alu_settings.svh */
//////////////////////////////////////////////////
// width settings for the relay ALU subsystem
// flag logic reads the top bit as sign, so keep
// ALU_WIDTH at 2 or more; op-codes need 3 bits
//////////////////////////////////////////////////

`ifndef RELAY_ALU_SETTINGS_SVH
`define RELAY_ALU_SETTINGS_SVH

// operand, sum and result width
`define ALU_WIDTH 8

// op-code width
// eight functions in the relay machine
`define ALU_OP_WIDTH 3

`endif

/* run_sim.sh */
#!/bin/sh
# build the relay ALU testbench with Verilator and run it
# exit status is nonzero when the build, the run or the check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f relay_alu.f --top-module tb_relay_alu -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_relay_alu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "no pass line in $LOG"
  exit 1
fi
exit 0

/* test/tb_clock_gen.sv */
//////////////////////////////////////////////////
// testbench clock and reset source
// 40 ns period, rst_n low for the first 8 edges
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 8;

  // reset released on a rising edge, like any other driven input
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire

/* test/tb_relay_alu.sv */
//////////////////////////////////////////////////
// relay ALU testbench with shadow B/C and a result queue
// checks run in concurrent assertions on result_valid
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "relay_alu_settings.svh"
`default_nettype none

module tb_relay_alu;

  import relay_alu_pkg::*;

  localparam int RESET_TIMEOUT = 20;
  localparam int DRAIN_TIMEOUT = 10;
  localparam int RANDOM_CYCLES = 240;

  logic                  clk;
  logic                  rst_n;
  logic                  load_b;
  logic                  load_c;
  logic [`ALU_WIDTH-1:0] b_data;
  logic [`ALU_WIDTH-1:0] c_data;
  logic                  op_strobe;
  alu_op_e               op;
  logic                  result_valid;
  alu_result_t           result;

  // reference state
  logic [`ALU_WIDTH-1:0] shadow_b;
  logic [`ALU_WIDTH-1:0] shadow_c;
  alu_result_t           exp_q[$];
  alu_result_t           exp_head;
  logic                  op_seen;
  logic                  timed_out;
  integer                seed;
  int                    error_count;
  int                    check_count;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  relay_alu DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_b       (load_b),
    .load_c       (load_c),
    .b_data       (b_data),
    .c_data       (c_data),
    .op_strobe    (op_strobe),
    .op           (op),
    .result_valid (result_valid),
    .result       (result)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic alu_result_t expected_result(input alu_op_e f,
                                                  input logic [`ALU_WIDTH-1:0] b,
                                                  input logic [`ALU_WIDTH-1:0] c);
    logic [`ALU_WIDTH:0] wide;
    alu_result_t         r;
    r = '0;
    case (f)
      OP_ADD: begin
        wide          = {1'b0, b} + {1'b0, c};
        r.data        = wide[`ALU_WIDTH-1:0];
        r.flags.carry = wide[`ALU_WIDTH];
      end
      OP_INC: begin
        wide          = {1'b0, b} + {{`ALU_WIDTH{1'b0}}, 1'b1};
        r.data        = wide[`ALU_WIDTH-1:0];
        r.flags.carry = wide[`ALU_WIDTH];
      end
      OP_AND: r.data = b & c;
      OP_OR:  r.data = b | c;
      OP_XOR: r.data = b ^ c;
      OP_NOT: r.data = ~b;
      // msb wraps round to bit 0
      OP_ROL: r.data = (b << 1) | (b >> (`ALU_WIDTH-1));
      OP_CLR: r.data = '0;
    endcase
    r.flags.sign = r.data[`ALU_WIDTH-1];
    r.flags.zero = (r.data == '0);
    return r;
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // one clock of inputs where op sees the registers as they stand before this load
  task automatic drive_cycle(input logic ld_b, input logic [`ALU_WIDTH-1:0] b_val,
                             input logic ld_c, input logic [`ALU_WIDTH-1:0] c_val,
                             input logic strobe, input alu_op_e op_val);
    @(posedge clk);
    load_b    <= ld_b;
    b_data    <= b_val;
    load_c    <= ld_c;
    c_data    <= c_val;
    op_strobe <= strobe;
    op        <= op_val;
    if (strobe) begin
      exp_q.push_back(expected_result(op_val, shadow_b, shadow_c));
      op_seen <= 1'b1;
    end
    if (ld_b) shadow_b = b_val;
    if (ld_c) shadow_c = c_val;
  endtask

  task automatic wait_reset_release(output logic expired);
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    expired = !rst_n;
  endtask

  task automatic run_directed();
    // idle cycles with nothing expected out
    repeat (3) drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b0, OP_ADD);
    drive_cycle(1'b1, 8'hff, 1'b1, 8'h01, 1'b0, OP_ADD);
    // add and inc wrap to zero with carry back to back
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_ADD);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_INC);
    // and uses the old b while b loads in the same cycle
    drive_cycle(1'b1, 8'h5a, 1'b0, 8'h00, 1'b1, OP_AND);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_OR);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_XOR);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_NOT);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_ROL);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_CLR);
    drive_cycle(1'b0, 8'h00, 1'b1, 8'h80, 1'b0, OP_ADD);
    // sign set without carry
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1, OP_ADD);
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b0, OP_ADD);
  endtask

  task automatic run_random();
    logic [31:0] ctl;
    logic [31:0] val;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      ctl = $random(seed);
      val = $random(seed);
      // strobe about three cycles in four
      drive_cycle(ctl[0], val[7:0], ctl[1], val[15:8], ctl[2] | ctl[3],
                  alu_op_e'(ctl[6:4]));
    end
    drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b0, OP_ADD);
  endtask

  task automatic drain_results(output logic expired);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    expired = (exp_q.size() != 0);
    // let the last result pass its check
    @(posedge clk);
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////

  // front of queue moves to exp_head between edges
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        $display("result_valid pulsed with no operation pending");
        error_count++;
      end else begin
        exp_head = exp_q.pop_front();
        check_count++;
      end
    end
  end

  // each strobe gives its valid pulse on the very next edge
  a_valid_after_op: assert property (@(posedge clk) disable iff (!rst_n)
    op_strobe |=> result_valid)
    else begin
      $display("mismatch result_valid: expected %h actual %h",
               1'b1, $sampled(result_valid));
      error_count++;
    end

  a_no_valid_without_op: assert property (@(posedge clk) disable iff (!rst_n)
    !op_strobe |=> !result_valid)
    else begin
      $display("mismatch result_valid: expected %h actual %h",
               1'b0, $sampled(result_valid));
      error_count++;
    end

  a_result_data: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result.data == exp_head.data)
    else begin
      $display("mismatch result.data: expected %h actual %h",
               $sampled(exp_head.data), $sampled(result.data));
      error_count++;
    end

  a_result_flags: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result.flags == exp_head.flags)
    else begin
      $display("mismatch result.flags: expected %h actual %h",
               $sampled(exp_head.flags), $sampled(result.flags));
      error_count++;
    end

  // quiet and cleared until the first op goes in
  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !op_seen |-> !result_valid && result == '0)
    else begin
      $display("mismatch result before first op: expected 0 actual valid %h result %h",
               $sampled(result_valid), $sampled(result));
      error_count++;
    end

  initial begin
    seed        = 32'h97e3_092c;
    load_b      = 1'b0;
    load_c      = 1'b0;
    b_data      = '0;
    c_data      = '0;
    op_strobe   = 1'b0;
    op          = OP_ADD;
    shadow_b    = '0;
    shadow_c    = '0;
    exp_head    = '0;
    op_seen     = 1'b0;
    error_count = 0;
    check_count = 0;
    wait_reset_release(timed_out);
    if (timed_out) begin
      $display("timeout: reset was never released");
    end else begin
      run_directed();
      run_random();
      drain_results(timed_out);
      if (timed_out) begin
        $display("timeout: %0d results never arrived", exp_q.size());
      end
    end
    $display("results checked %0d, errors %0d", check_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

`default_nettype wire
